//--- src/fpu_pkg.sv
// shared widths, word types, operation codes and constants for the scalar fpu; import where needed
`default_nettype none

package fpu_pkg;

	// format field widths
	localparam int S_EXP_W = 8;
	localparam int D_EXP_W = 11;
	localparam int S_MAN_W = 23;
	localparam int D_MAN_W = 52;

	typedef logic [63:0] fp_word_t;		// one float register
	typedef logic [63:0] xlen_word_t;	// one integer register
	typedef logic [4:0]  reg_idx_t;
	typedef logic [2:0]  fp_mode_t;		// function-select field, meaning depends on op

	typedef logic [D_EXP_W-1:0] exp_t;	// exponent in double width
	typedef logic [D_MAN_W-1:0] man_t;	// fraction, left aligned
	typedef logic [9:0]         class_mask_t;

	typedef enum logic [2:0] {
		op_sgnj,
		op_minmax,
		op_cmp,
		op_class,
		op_mv_x,
		op_mv_f
	} fpu_op_t;

	typedef enum logic {
		fmt_s,
		fmt_d
	} fp_fmt_t;

	// upper word of a properly boxed single
	localparam logic [31:0] S_BOX = 32'hffff_ffff;

	localparam fp_word_t CANON_NAN_S = {S_BOX, 32'h7fc0_0000};
	localparam fp_word_t CANON_NAN_D = 64'h7ff8_0000_0000_0000;

	// fclass bit positions
	localparam int CLS_NEG_INF  = 0;
	localparam int CLS_NEG_NORM = 1;
	localparam int CLS_NEG_SUB  = 2;
	localparam int CLS_NEG_ZERO = 3;
	localparam int CLS_POS_ZERO = 4;
	localparam int CLS_POS_SUB  = 5;
	localparam int CLS_POS_NORM = 6;
	localparam int CLS_POS_INF  = 7;
	localparam int CLS_SNAN     = 8;
	localparam int CLS_QNAN     = 9;

endpackage

`default_nettype wire

//--- src/fp_class_if.sv
// decoded fields of one operand, driven by an unpacker and read by the compare and class units
`timescale 1ns/1ps
`default_nettype none

interface fp_class_if;
	import fpu_pkg::*;

	logic sign;
	exp_t exp;	// re-biased to double
	man_t man;

	// special-value flags, at most one of nan/inf/zero/sub set
	logic is_nan;
	logic is_snan;
	logic is_inf;
	logic is_zero;
	logic is_sub;

	modport producer (
		output sign, exp, man,
		output is_nan, is_snan, is_inf, is_zero, is_sub
	);

	modport consumer (
		input sign, exp, man,
		input is_nan, is_snan, is_inf, is_zero, is_sub
	);

endinterface

`default_nettype wire

//--- src/fpu_issue_stage.sv
// issue register of the fpu; latches an operation and its operands on the cycle it is accepted
`timescale 1ns/1ps
`default_nettype none

module fpu_issue_stage (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               in_valid,
	input  wire fpu_pkg::fpu_op_t   op,
	input  wire fpu_pkg::fp_fmt_t   fmt,
	input  wire fpu_pkg::fp_mode_t  mode,
	input  wire fpu_pkg::reg_idx_t  rd,
	input  wire fpu_pkg::fp_word_t  fr1,
	input  wire fpu_pkg::fp_word_t  fr2,
	input  wire fpu_pkg::xlen_word_t ir1,
	output logic                    iss_valid,
	output fpu_pkg::fpu_op_t        iss_op,
	output fpu_pkg::fp_fmt_t        iss_fmt,
	output fpu_pkg::fp_mode_t       iss_mode,
	output fpu_pkg::reg_idx_t       iss_rd,
	output fpu_pkg::fp_word_t       iss_fr1,
	output fpu_pkg::fp_word_t       iss_fr2,
	output fpu_pkg::xlen_word_t     iss_ir1
);
	import fpu_pkg::*;

	// valid is a one-cycle pulse per accepted op
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			iss_valid <= 1'b0;
		end else begin
			iss_valid <= in_valid;
		end
	end

	// payload only moves when something is issued
	always_ff @(posedge clk) begin
		if (in_valid) begin
			iss_op   <= op;
			iss_fmt  <= fmt;
			iss_mode <= mode;
			iss_rd   <= rd;
			iss_fr1  <= fr1;
			iss_fr2  <= fr2;
			iss_ir1  <= ir1;
		end
	end

endmodule

`default_nettype wire

//--- src/fp_unpack.sv
// splits one float register into sign, widened exponent, aligned fraction and special-value flags
`timescale 1ns/1ps
`default_nettype none

module fp_unpack (
	input  wire fpu_pkg::fp_word_t word,
	input  wire fpu_pkg::fp_fmt_t  fmt,
	fp_class_if.producer           fields
);
	import fpu_pkg::*;

	logic     boxed;
	fp_word_t src;
	logic [S_EXP_W-1:0] s_exp;
	logic     exp_max;
	logic     man_zero;

	// an unboxed single is decoded as the canonical quiet nan
	assign boxed = (word[63:32] == S_BOX);
	assign src   = (fmt == fmt_s && !boxed) ? CANON_NAN_S : word;
	assign s_exp = src[S_EXP_W+S_MAN_W-1:S_MAN_W];

	always_comb begin
		if (fmt == fmt_d) begin
			fields.sign = src[63];
			fields.exp  = src[D_EXP_W+D_MAN_W-1:D_MAN_W];
			fields.man  = src[D_MAN_W-1:0];
		end else begin
			fields.sign = src[31];
			fields.man  = {src[S_MAN_W-1:0], {(D_MAN_W-S_MAN_W){1'b0}}};
			// keep the zero and all-ones codes, re-bias everything else
			if (s_exp == '0)
				fields.exp = '0;
			else if (s_exp == '1)
				fields.exp = '1;
			else
				fields.exp = exp_t'(s_exp) + exp_t'(2**(D_EXP_W-1) - 2**(S_EXP_W-1));
		end
	end

	assign exp_max  = (fields.exp == '1);
	assign man_zero = (fields.man == '0);

	assign fields.is_nan  = exp_max && !man_zero;
	assign fields.is_snan = exp_max && !man_zero && !fields.man[D_MAN_W-1];	// quiet bit clear
	assign fields.is_inf  = exp_max && man_zero;
	assign fields.is_zero = (fields.exp == '0) && man_zero;
	assign fields.is_sub  = (fields.exp == '0) && !man_zero;

endmodule

`default_nettype wire

//--- src/fp_compare.sv
// orders two unpacked operands for fle/flt/feq and picks the fmin/fmax result
`timescale 1ns/1ps
`default_nettype none

module fp_compare (
	fp_class_if.consumer           a,
	fp_class_if.consumer           b,
	input  wire fpu_pkg::fp_word_t fr1,
	input  wire fpu_pkg::fp_word_t fr2,
	input  wire fpu_pkg::fp_fmt_t  fmt,
	input  wire fpu_pkg::fp_mode_t mode,
	output logic                   cmp_bit,
	output fpu_pkg::fp_word_t      minmax_res
);
	import fpu_pkg::*;

	logic lt;	// a strictly below b
	logic eq;
	logic unordered;

	assign unordered = a.is_nan || b.is_nan;

	// sign first, so -0 sorts below +0
	always_comb begin
		lt = 1'b0;
		eq = 1'b0;
		if (a.sign != b.sign) begin
			lt = a.sign;
		end else if (a.is_inf || b.is_inf) begin
			if (a.is_inf && b.is_inf)
				eq = 1'b1;
			else
				lt = !(a.is_inf ^ a.sign);
		end else if (a.exp != b.exp) begin
			lt = (a.exp < b.exp) ^ a.sign;	// magnitude order flips when negative
		end else if (a.man != b.man) begin
			lt = (a.man < b.man) ^ a.sign;
		end else begin
			eq = 1'b1;
		end
	end

	always_comb begin
		if (unordered) begin
			cmp_bit = 1'b0;
		end else begin
			case (mode)
				3'd0:    cmp_bit = lt || eq;	// fle
				3'd1:    cmp_bit = lt;		// flt
				3'd2:    cmp_bit = eq;		// feq
				default: cmp_bit = 1'b0;
			endcase
		end
	end

	// mode[0] selects max
	always_comb begin
		if (a.is_nan && b.is_nan)
			minmax_res = (fmt == fmt_d) ? CANON_NAN_D : CANON_NAN_S;
		else if (a.is_nan)
			minmax_res = fr2;
		else if (b.is_nan)
			minmax_res = fr1;
		else
			minmax_res = (lt ^ mode[0]) ? fr1 : fr2;
	end

endmodule

`default_nettype wire

//--- src/fp_move_sign.sv
// sign injection and the float/integer register moves, with boxing of singles
`timescale 1ns/1ps
`default_nettype none

module fp_move_sign (
	input  wire fpu_pkg::fpu_op_t    op,
	input  wire fpu_pkg::fp_fmt_t    fmt,
	input  wire fpu_pkg::fp_mode_t   mode,
	input  wire fpu_pkg::fp_word_t   fr1,
	input  wire fpu_pkg::fp_word_t   fr2,
	input  wire fpu_pkg::xlen_word_t ir1,
	output fpu_pkg::fp_word_t        sgnj_res,
	output fpu_pkg::xlen_word_t      mv_res
);
	import fpu_pkg::*;

	logic sign_a;
	logic sign_b;
	logic new_sign;

	assign sign_a = (fmt == fmt_d) ? fr1[63] : fr1[31];
	assign sign_b = (fmt == fmt_d) ? fr2[63] : fr2[31];

	always_comb begin
		case (mode)
			3'd0:    new_sign = sign_b;		// fsgnj
			3'd1:    new_sign = ~sign_b;	// fsgnjn
			default: new_sign = sign_a ^ sign_b;	// fsgnjx
		endcase
	end

	// single keeps the box bits of fr1
	assign sgnj_res = (fmt == fmt_d) ? {new_sign, fr1[62:0]} :
		{fr1[63:32], new_sign, fr1[30:0]};

	always_comb begin
		if (op == op_mv_f) begin
			if (fmt == fmt_d)
				mv_res = ir1;
			else
				mv_res = {S_BOX, ir1[31:0]};	// box into the float file
		end else begin
			if (fmt == fmt_d)
				mv_res = fr1;
			else
				mv_res = {{32{fr1[31]}}, fr1[31:0]};	// sign extend for the int file
		end
	end

endmodule

`default_nettype wire

//--- src/fp_classify.sv
// fclass: one-hot ten-bit class mask from the unpacked flags of a single operand
`timescale 1ns/1ps
`default_nettype none

module fp_classify (
	fp_class_if.consumer         a,
	output fpu_pkg::class_mask_t class_res
);
	import fpu_pkg::*;

	always_comb begin
		class_res = '0;
		if (a.is_nan) begin
			if (a.is_snan)
				class_res[CLS_SNAN] = 1'b1;
			else
				class_res[CLS_QNAN] = 1'b1;
		end else if (a.is_inf) begin
			if (a.sign)
				class_res[CLS_NEG_INF] = 1'b1;
			else
				class_res[CLS_POS_INF] = 1'b1;
		end else if (a.is_zero) begin
			if (a.sign)
				class_res[CLS_NEG_ZERO] = 1'b1;
			else
				class_res[CLS_POS_ZERO] = 1'b1;
		end else if (a.is_sub) begin
			if (a.sign)
				class_res[CLS_NEG_SUB] = 1'b1;
			else
				class_res[CLS_POS_SUB] = 1'b1;
		end else begin
			// whatever is left is normal
			if (a.sign)
				class_res[CLS_NEG_NORM] = 1'b1;
			else
				class_res[CLS_POS_NORM] = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- src/fpu_result_stage.sv
// picks the result of the issued op and registers it with its destination and register-file flag
`timescale 1ns/1ps
`default_nettype none

module fpu_result_stage (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic                 iss_valid,
	input  wire fpu_pkg::fpu_op_t     iss_op,
	input  wire fpu_pkg::fp_mode_t    iss_mode,
	input  wire fpu_pkg::reg_idx_t    iss_rd,
	input  wire fpu_pkg::fp_word_t    sgnj_res,
	input  wire fpu_pkg::fp_word_t    minmax_res,
	input  wire fpu_pkg::xlen_word_t  mv_res,
	input  wire logic                 cmp_bit,
	input  wire fpu_pkg::class_mask_t class_res,
	output logic                      out_valid,
	output fpu_pkg::fp_word_t         result,
	output fpu_pkg::reg_idx_t         res_rd,
	output logic                      res_fp
);
	import fpu_pkg::*;

	fp_word_t sel_res;
	logic     sel_fp;
	logic     mode_ok;

	// reserved function codes write zero
	always_comb begin
		case (iss_op)
			op_sgnj,
			op_cmp:    mode_ok = (iss_mode <= 3'd2);
			op_minmax: mode_ok = (iss_mode <= 3'd1);
			default:   mode_ok = 1'b1;
		endcase
	end

	always_comb begin
		sel_res = '0;
		sel_fp  = 1'b0;
		case (iss_op)
			op_sgnj: begin
				sel_res = sgnj_res;
				sel_fp  = 1'b1;
			end
			op_minmax: begin
				sel_res = minmax_res;
				sel_fp  = 1'b1;
			end
			op_cmp:   sel_res = {63'b0, cmp_bit};
			op_class: sel_res = {54'b0, class_res};
			op_mv_x:  sel_res = mv_res;
			op_mv_f: begin
				sel_res = mv_res;
				sel_fp  = 1'b1;
			end
			default: begin
				sel_res = '0;
				sel_fp  = 1'b0;
			end
		endcase
		if (!mode_ok)
			sel_res = '0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= iss_valid;
		end
	end

	always_ff @(posedge clk) begin
		result <= sel_res;
		res_rd <= iss_rd;
		res_fp <= sel_fp;	// 1 = float register file
	end

endmodule

`default_nettype wire

//--- src/fpu_misc_top.sv
// top of the single-cycle fpu ops: issue register, unpackers, data units, result register
`timescale 1ns/1ps
`default_nettype none

module fpu_misc_top (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                in_valid,
	input  wire fpu_pkg::fpu_op_t    op,
	input  wire fpu_pkg::fp_fmt_t    fmt,
	input  wire fpu_pkg::fp_mode_t   mode,
	input  wire fpu_pkg::reg_idx_t   rd,
	input  wire fpu_pkg::fp_word_t   fr1,
	input  wire fpu_pkg::fp_word_t   fr2,
	input  wire fpu_pkg::xlen_word_t ir1,
	output logic                     out_valid,
	output fpu_pkg::fp_word_t        result,
	output fpu_pkg::reg_idx_t        res_rd,
	output logic                     res_fp
);
	import fpu_pkg::*;

	logic        iss_valid;
	fpu_op_t     iss_op;
	fp_fmt_t     iss_fmt;
	fp_mode_t    iss_mode;
	reg_idx_t    iss_rd;
	fp_word_t    iss_fr1;
	fp_word_t    iss_fr2;
	xlen_word_t  iss_ir1;

	fp_word_t    sgnj_res;
	fp_word_t    minmax_res;
	xlen_word_t  mv_res;
	logic        cmp_bit;
	class_mask_t class_res;

	fp_class_if opa_if ();
	fp_class_if opb_if ();

	fpu_issue_stage u_issue (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.op        (op),
		.fmt       (fmt),
		.mode      (mode),
		.rd        (rd),
		.fr1       (fr1),
		.fr2       (fr2),
		.ir1       (ir1),
		.iss_valid (iss_valid),
		.iss_op    (iss_op),
		.iss_fmt   (iss_fmt),
		.iss_mode  (iss_mode),
		.iss_rd    (iss_rd),
		.iss_fr1   (iss_fr1),
		.iss_fr2   (iss_fr2),
		.iss_ir1   (iss_ir1)
	);

	// one unpacker per float operand
	fp_unpack u_unpack_a (
		.word   (iss_fr1),
		.fmt    (iss_fmt),
		.fields (opa_if.producer)
	);

	fp_unpack u_unpack_b (
		.word   (iss_fr2),
		.fmt    (iss_fmt),
		.fields (opb_if.producer)
	);

	fp_compare u_compare (
		.a          (opa_if.consumer),
		.b          (opb_if.consumer),
		.fr1        (iss_fr1),
		.fr2        (iss_fr2),
		.fmt        (iss_fmt),
		.mode       (iss_mode),
		.cmp_bit    (cmp_bit),
		.minmax_res (minmax_res)
	);

	fp_move_sign u_move_sign (
		.op       (iss_op),
		.fmt      (iss_fmt),
		.mode     (iss_mode),
		.fr1      (iss_fr1),
		.fr2      (iss_fr2),
		.ir1      (iss_ir1),
		.sgnj_res (sgnj_res),
		.mv_res   (mv_res)
	);

	fp_classify u_classify (
		.a         (opa_if.consumer),
		.class_res (class_res)
	);

	fpu_result_stage u_result (
		.clk        (clk),
		.rst_n      (rst_n),
		.iss_valid  (iss_valid),
		.iss_op     (iss_op),
		.iss_mode   (iss_mode),
		.iss_rd     (iss_rd),
		.sgnj_res   (sgnj_res),
		.minmax_res (minmax_res),
		.mv_res     (mv_res),
		.cmp_bit    (cmp_bit),
		.class_res  (class_res),
		.out_valid  (out_valid),
		.result     (result),
		.res_rd     (res_rd),
		.res_fp     (res_fp)
	);

endmodule

`default_nettype wire

//--- test/tb_fpu_misc.sv
// directed testbench for fpu_misc_top; run through sources.f, prints a one-line summary at the end
`timescale 1ns/1ps
`default_nettype none

module tb_fpu_misc;
	import fpu_pkg::*;

	localparam int MAX_CYCLES = 2000;	// about four times the directed sequence

	localparam fp_word_t P_INF_D  = 64'h7ff0_0000_0000_0000;
	localparam fp_word_t N_INF_D  = 64'hfff0_0000_0000_0000;
	localparam fp_word_t Q_NAN_D  = 64'h7ff8_0000_0000_0000;
	localparam fp_word_t SNAN_D   = 64'h7ff0_0000_0000_0001;
	localparam fp_word_t N_ZERO_D = 64'h8000_0000_0000_0000;
	localparam fp_word_t P_INF_S  = 64'hffff_ffff_7f80_0000;
	localparam fp_word_t Q_NAN_S  = 64'hffff_ffff_7fc0_0000;
	localparam fp_word_t SNAN_S   = 64'hffff_ffff_7f80_0001;
	localparam fp_word_t P_ZERO_S = 64'hffff_ffff_0000_0000;
	localparam fp_word_t N_ZERO_S = 64'hffff_ffff_8000_0000;

	logic       clk;
	logic       rst_n;
	logic       in_valid;
	fpu_op_t    op;
	fp_fmt_t    fmt;
	fp_mode_t   mode;
	reg_idx_t   rd;
	fp_word_t   fr1;
	fp_word_t   fr2;
	xlen_word_t ir1;
	logic       out_valid;
	fp_word_t   result;
	reg_idx_t   res_rd;
	logic       res_fp;

	int          err_val = 0;	// wrong values
	int          err_proto = 0;	// missing or extra out_valid
	int          cycles = 0;

	fpu_misc_top UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.op        (op),
		.fmt       (fmt),
		.mode      (mode),
		.rd        (rd),
		.fr1       (fr1),
		.fr2       (fr2),
		.ir1       (ir1),
		.out_valid (out_valid),
		.result    (result),
		.res_rd    (res_rd),
		.res_fp    (res_fp)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// random normal operands, never nan or inf
	function automatic fp_word_t rand_d();
		logic [10:0] e;
		e = 11'(1 + ($urandom % 2046));
		return {1'($urandom), e, 20'($urandom), 32'($urandom)};
	endfunction

	function automatic fp_word_t rand_s();
		return {32'hffff_ffff, 1'($urandom), 8'(1 + ($urandom % 254)), 23'($urandom)};
	endfunction

	function automatic logic sign_w(fp_word_t w, fp_fmt_t f);
		return (f == fmt_d) ? w[63] : w[31];
	endfunction

	function automatic logic zero_w(fp_word_t w, fp_fmt_t f);
		return (f == fmt_d) ? (w[62:0] == '0) : (w[30:0] == '0);
	endfunction

	// unboxed singles count as nan
	function automatic logic nan_w(fp_word_t w, fp_fmt_t f);
		if (f == fmt_d)
			return (w[62:52] == 11'h7ff) && (w[51:0] != '0);
		if (w[63:32] != 32'hffff_ffff)
			return 1'b1;
		return (w[30:23] == 8'hff) && (w[22:0] != '0);
	endfunction

	// exact for normals, zeros and inf; no subnormal singles go through here
	function automatic fp_word_t widen_single(fp_word_t w);
		logic [10:0] e;
		e = 11'(w[30:23]) + 11'd896;	// bias 127 -> 1023
		if (w[30:23] == 8'h00)
			return {w[31], 63'b0};
		else if (w[30:23] == 8'hff)
			return {w[31], 11'h7ff, w[22:0], 29'b0};
		return {w[31], e, w[22:0], 29'b0};
	endfunction

	function automatic real to_real(fp_word_t w, fp_fmt_t f);
		return $bitstoreal((f == fmt_d) ? w : widen_single(w));
	endfunction

	// real ordering, except that -0 sits below +0
	function automatic logic ref_lt(fp_word_t a, fp_word_t b, fp_fmt_t f);
		if (zero_w(a, f) && zero_w(b, f))
			return sign_w(a, f) && !sign_w(b, f);
		return to_real(a, f) < to_real(b, f);
	endfunction

	function automatic logic ref_eq(fp_word_t a, fp_word_t b, fp_fmt_t f);
		if (zero_w(a, f) && zero_w(b, f))
			return sign_w(a, f) == sign_w(b, f);
		return to_real(a, f) == to_real(b, f);
	endfunction

	function automatic fp_word_t exp_cmp(fp_mode_t m, fp_word_t a, fp_word_t b, fp_fmt_t f);
		logic bit_v;
		if (nan_w(a, f) || nan_w(b, f))
			bit_v = 1'b0;
		else if (m == 3'd0)
			bit_v = ref_lt(a, b, f) || ref_eq(a, b, f);
		else if (m == 3'd1)
			bit_v = ref_lt(a, b, f);
		else
			bit_v = ref_eq(a, b, f);
		return {63'b0, bit_v};
	endfunction

	function automatic fp_word_t exp_minmax(fp_mode_t m, fp_word_t a, fp_word_t b, fp_fmt_t f);
		if (nan_w(a, f) && nan_w(b, f))
			return (f == fmt_d) ? 64'h7ff8_0000_0000_0000 : {32'hffff_ffff, 32'h7fc0_0000};
		if (nan_w(a, f))
			return b;
		if (nan_w(b, f))
			return a;
		if (m[0])
			return ref_lt(a, b, f) ? b : a;	// max
		return ref_lt(b, a, f) ? b : a;
	endfunction

	function automatic fp_word_t exp_sgnj(fp_mode_t m, fp_word_t a, fp_word_t b, fp_fmt_t f);
		logic ns;
		case (m)
			3'd0:    ns = sign_w(b, f);
			3'd1:    ns = !sign_w(b, f);
			default: ns = sign_w(a, f) ^ sign_w(b, f);
		endcase
		if (f == fmt_d)
			return {ns, a[62:0]};
		return {a[63:32], ns, a[30:0]};
	endfunction

	function automatic fp_word_t exp_move(fpu_op_t o, fp_fmt_t f, fp_word_t a, xlen_word_t iv);
		if (o == op_mv_f)
			return (f == fmt_d) ? iv : {32'hffff_ffff, iv[31:0]};
		return (f == fmt_d) ? a : {{32{a[31]}}, a[31:0]};
	endfunction

	function automatic logic dest_fp(fpu_op_t o);
		return (o == op_sgnj) || (o == op_minmax) || (o == op_mv_f);
	endfunction

	task automatic issue(input fpu_op_t o, input fp_fmt_t f, input fp_mode_t m,
		input reg_idx_t r, input fp_word_t a, input fp_word_t b, input xlen_word_t iv);
		in_valid = 1'b1;
		op       = o;
		fmt      = f;
		mode     = m;
		rd       = r;
		fr1      = a;
		fr2      = b;
		ir1      = iv;
	endtask

	task automatic check_out(input fp_word_t exp_res, input reg_idx_t exp_rd,
		input logic exp_fp, input string name);
		if (!out_valid) begin
			err_proto++;
			$display("%0t: out_valid missing for %s", $time, name);
		end else begin
			if (result !== exp_res) begin
				err_val++;
				$display("ERR %0t: %s result %h, expected %h", $time, name, result, exp_res);
			end
			if (res_rd !== exp_rd) begin
				err_val++;
				$display("ERR %0t: %s res_rd %0d, expected %0d", $time, name, res_rd, exp_rd);
			end
			if (res_fp !== exp_fp) begin
				err_val++;
				$display("ERR %0t: %s res_fp %b, expected %b", $time, name, res_fp, exp_fp);
			end
		end
	endtask

	// one isolated op, result looked at two falling edges after issue
	task automatic run_op(input fpu_op_t o, input fp_fmt_t f, input fp_mode_t m,
		input fp_word_t a, input fp_word_t b, input xlen_word_t iv,
		input fp_word_t exp_res, input string name);
		reg_idx_t r;
		r = 5'($urandom);
		@(negedge clk);
		issue(o, f, m, r, a, b, iv);
		@(negedge clk);
		in_valid = 1'b0;
		if (out_valid) begin
			err_proto++;
			$display("%0t: out_valid came a cycle early for %s", $time, name);
		end
		@(negedge clk);
		check_out(exp_res, r, dest_fp(o), name);
	endtask

	task automatic cmp_modes(input fp_word_t a, input fp_word_t b, input fp_fmt_t f,
		input string name);
		for (int m = 0; m < 3; m++)
			run_op(op_cmp, f, 3'(m), a, b, '0, exp_cmp(3'(m), a, b, f), name);
	endtask

	task automatic minmax_both(input fp_word_t a, input fp_word_t b, input fp_fmt_t f,
		input string name);
		for (int m = 0; m < 2; m++)
			run_op(op_minmax, f, 3'(m), a, b, '0, exp_minmax(3'(m), a, b, f), name);
	endtask

	task automatic test_reset();
		repeat (5) begin
			@(negedge clk);
			if (out_valid !== 1'b0) begin
				err_proto++;
				$display("%0t: out_valid not low during reset", $time);
			end
		end
		rst_n = 1'b1;
		repeat (3) begin
			@(negedge clk);
			if (out_valid !== 1'b0) begin
				err_proto++;
				$display("%0t: out_valid high after reset with nothing issued", $time);
			end
		end
	endtask

	task automatic test_sgnj_moves();
		fp_word_t   a;
		fp_word_t   b;
		xlen_word_t iv;
		for (int k = 0; k < 4; k++) begin
			for (int m = 0; m < 3; m++) begin
				a = rand_d();
				b = rand_d();
				run_op(op_sgnj, fmt_d, 3'(m), a, b, '0, exp_sgnj(3'(m), a, b, fmt_d), "fsgnj.d");
				a = rand_s();
				b = rand_s();
				run_op(op_sgnj, fmt_s, 3'(m), a, b, '0, exp_sgnj(3'(m), a, b, fmt_s), "fsgnj.s");
			end
			a = rand_s();
			a[31] = 1'(k);	// both sign-extension cases
			run_op(op_mv_x, fmt_s, 3'd0, a, '0, '0, exp_move(op_mv_x, fmt_s, a, '0), "fmv.x.w");
			a = rand_d();
			run_op(op_mv_x, fmt_d, 3'd0, a, '0, '0, exp_move(op_mv_x, fmt_d, a, '0), "fmv.x.d");
			iv = {32'($urandom), 32'($urandom)};
			run_op(op_mv_f, fmt_s, 3'd0, '0, '0, iv, exp_move(op_mv_f, fmt_s, '0, iv), "fmv.w.x");
			run_op(op_mv_f, fmt_d, 3'd0, '0, '0, iv, exp_move(op_mv_f, fmt_d, '0, iv), "fmv.d.x");
		end
	endtask

	task automatic test_compare();
		fp_word_t x;
		fp_word_t y;
		for (int k = 0; k < 6; k++) begin
			x = rand_d();
			y = rand_d();
			cmp_modes(x, y, fmt_d, "cmp.d random");
		end
		x = rand_d();
		cmp_modes(x, x, fmt_d, "cmp.d equal");
		cmp_modes('0, N_ZERO_D, fmt_d, "cmp.d +0 -0");
		cmp_modes(N_ZERO_D, '0, fmt_d, "cmp.d -0 +0");
		cmp_modes(P_INF_D, x, fmt_d, "cmp.d +inf");
		cmp_modes(x, N_INF_D, fmt_d, "cmp.d -inf");
		cmp_modes(P_INF_D, P_INF_D, fmt_d, "cmp.d inf inf");
		cmp_modes(Q_NAN_D, x, fmt_d, "cmp.d nan");
		cmp_modes(x, SNAN_D, fmt_d, "cmp.d snan");
		x = rand_s();
		y = rand_s();
		cmp_modes(x, y, fmt_s, "cmp.s random");
		cmp_modes(x, x, fmt_s, "cmp.s equal");
		cmp_modes(P_ZERO_S, N_ZERO_S, fmt_s, "cmp.s +0 -0");
		cmp_modes(P_INF_S, x, fmt_s, "cmp.s +inf");
		cmp_modes(x, Q_NAN_S, fmt_s, "cmp.s nan");
		cmp_modes({32'h0, x[31:0]}, x, fmt_s, "cmp.s unboxed");
	endtask

	task automatic test_minmax();
		fp_word_t x;
		fp_word_t y;
		for (int k = 0; k < 3; k++) begin
			x = rand_d();
			y = rand_d();
			minmax_both(x, y, fmt_d, "minmax.d random");
		end
		minmax_both(Q_NAN_D, x, fmt_d, "minmax.d nan a");
		minmax_both(x, SNAN_D, fmt_d, "minmax.d nan b");
		minmax_both(Q_NAN_D, SNAN_D, fmt_d, "minmax.d both nan");
		minmax_both('0, N_ZERO_D, fmt_d, "minmax.d zeros");
		x = rand_s();
		y = rand_s();
		minmax_both(x, y, fmt_s, "minmax.s random");
		minmax_both(Q_NAN_S, y, fmt_s, "minmax.s nan a");
		minmax_both(Q_NAN_S, SNAN_S, fmt_s, "minmax.s both nan");
		minmax_both({32'h1234_5678, x[31:0]}, y, fmt_s, "minmax.s unboxed a");
		minmax_both(x, {32'h0, y[31:0]}, fmt_s, "minmax.s unboxed b");
		minmax_both({32'h0, x[31:0]}, {32'h0, y[31:0]}, fmt_s, "minmax.s both unboxed");
	endtask

	task automatic test_class();
		fp_word_t reps_d [10];
		fp_word_t reps_s [10];
		// ordered by class bit, -inf up to quiet nan
		reps_d = '{64'hfff0_0000_0000_0000, 64'hbff0_0000_0000_0000, 64'h8000_0000_0000_0001,
			64'h8000_0000_0000_0000, 64'h0000_0000_0000_0000, 64'h0008_0000_0000_0000,
			64'h3ff0_0000_0000_0000, 64'h7ff0_0000_0000_0000, 64'h7ff4_0000_0000_0000,
			64'h7ff8_0000_0000_0000};
		reps_s = '{64'hffff_ffff_ff80_0000, 64'hffff_ffff_bf80_0000, 64'hffff_ffff_8000_0001,
			64'hffff_ffff_8000_0000, 64'hffff_ffff_0000_0000, 64'hffff_ffff_0040_0000,
			64'hffff_ffff_3f80_0000, 64'hffff_ffff_7f80_0000, 64'hffff_ffff_7fa0_0000,
			64'hffff_ffff_7fc0_0000};
		for (int c = 0; c < 10; c++) begin
			run_op(op_class, fmt_d, 3'd0, reps_d[c], '0, '0, 64'(1) << c, "fclass.d");
			run_op(op_class, fmt_s, 3'd0, reps_s[c], '0, '0, 64'(1) << c, "fclass.s");
		end
		run_op(op_class, fmt_s, 3'd0, 64'h0000_0000_3f80_0000, '0, '0, 64'(1) << 9,
			"fclass.s unboxed");
	endtask

	// back to back issue, results expected in order one cycle apart
	task automatic test_pipeline();
		fp_word_t   q_res [$];
		reg_idx_t   q_rd [$];
		logic       q_fp [$];
		fpu_op_t    o;
		fp_fmt_t    f;
		fp_mode_t   m;
		fp_word_t   a;
		fp_word_t   b;
		fp_word_t   e;
		xlen_word_t iv;
		reg_idx_t   r;
		for (int i = 0; i < 14; i++) begin
			@(negedge clk);
			if (i >= 2) begin
				check_out(q_res.pop_front(), q_rd.pop_front(), q_fp.pop_front(), "pipeline");
			end else if (out_valid) begin
				err_proto++;
				$display("%0t: out_valid high before the first pipelined result", $time);
			end
			if (i < 12) begin
				a = rand_d();
				b = rand_d();
				iv = {32'($urandom), 32'($urandom)};
				r = 5'($urandom);
				f = fmt_d;
				m = 3'd0;
				case (i % 6)
					0: begin
						o = op_sgnj;
						m = 3'($urandom % 3);
						e = exp_sgnj(m, a, b, f);
					end
					1: begin
						o = op_cmp;
						m = 3'($urandom % 3);
						e = exp_cmp(m, a, b, f);
					end
					2: begin
						o = op_minmax;
						f = fmt_s;
						m = 3'($urandom % 2);
						a = rand_s();
						b = rand_s();
						e = exp_minmax(m, a, b, f);
					end
					3: begin
						o = op_mv_x;
						f = fmt_s;
						a = rand_s();
						e = exp_move(o, f, a, iv);
					end
					4: begin
						o = op_mv_f;
						e = exp_move(o, f, a, iv);
					end
					default: begin
						o = op_class;
						e = 64'(1) << (a[63] ? 1 : 6);	// random normal, class by sign
					end
				endcase
				q_res.push_back(e);
				q_rd.push_back(r);
				q_fp.push_back(dest_fp(o));
				issue(o, f, m, r, a, b, iv);
			end else begin
				in_valid = 1'b0;
			end
		end
		@(negedge clk);
		if (out_valid) begin
			err_proto++;
			$display("%0t: out_valid stayed high after the last pipelined result", $time);
		end
	endtask

	initial begin
		void'($urandom(12882));
		clk      = 1'b0;
		rst_n    = 1'b0;
		in_valid = 1'b0;
		op       = op_sgnj;
		fmt      = fmt_d;
		mode     = 3'd0;
		rd       = 5'd0;
		fr1      = '0;
		fr2      = '0;
		ir1      = '0;

		test_reset();
		test_sgnj_moves();
		test_compare();
		test_minmax();
		test_class();
		test_pipeline();

		@(negedge clk);
		$display("errors: %0d wrong values, %0d protocol", err_val, err_proto);
		if (err_val == 0 && err_proto == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
src/fpu_pkg.sv
src/fp_class_if.sv
src/fpu_issue_stage.sv
src/fp_unpack.sv
src/fp_compare.sv
src/fp_move_sign.sv
src/fp_classify.sv
src/fpu_result_stage.sv
src/fpu_misc_top.sv
test/tb_fpu_misc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the fpu testbench with Verilator, run it and look for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_fpu_misc -Mdir obj_dir -o sim_fpu
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out="$(./obj_dir/sim_fpu)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q "^TEST RESULT: PASS$"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1
